//--- src/breakout_pkg.sv
`default_nettype none

package breakout_pkg;

    // bus widths
    localparam int coord_w    = 10;
    localparam int rgb_w      = 12;
    localparam int digit_w    = 4;

    // playfield holds a fixed row of bricks
    localparam int num_bricks = 6;

    // visible area limits of the 640x480 raster
    localparam logic [coord_w-1:0] x_max = 10'd639;
    localparam logic [coord_w-1:0] y_max = 10'd479;

    // row just past the visible area that is seen once per frame at column 0
    localparam logic [coord_w-1:0] refresh_row = 10'd481;

    // ball is a square
    localparam logic [coord_w-1:0] ball_size = 10'd8;

    // player board
    localparam logic [coord_w-1:0] board_width  = 10'd64;
    localparam logic [coord_w-1:0] board_height = 10'd8;

    // every brick has the same size
    localparam logic [coord_w-1:0] brick_width  = 10'd30;
    localparam logic [coord_w-1:0] brick_height = 10'd30;

    // white board
    localparam logic [rgb_w-1:0] board_rgb = 12'hFFF;

    // red bricks
    localparam logic [rgb_w-1:0] brick_rgb = 12'hF00;

    // yellow ball with red and green on
    localparam logic [rgb_w-1:0] ball_rgb = 12'hFF0;

    // black background
    localparam logic [rgb_w-1:0] bg_rgb = 12'h000;

endpackage

`default_nettype wire

//--- src/ball_motion.sv
`default_nettype none

module ball_motion (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              pause,
    input  logic [breakout_pkg::coord_w-1:0]  x,
    input  logic [breakout_pkg::coord_w-1:0]  y,
    input  logic [breakout_pkg::coord_w-1:0]  board_x,
    input  logic [breakout_pkg::coord_w-1:0]  board_y,
    input  logic [breakout_pkg::num_bricks-1:0] hits,
    output logic [breakout_pkg::coord_w-1:0]  ball_x,
    output logic [breakout_pkg::coord_w-1:0]  ball_y,
    output logic                              step,
    output logic                              collision
);

    import breakout_pkg::*;

    // ball right and bottom edges
    logic [coord_w-1:0] ball_r;
    logic [coord_w-1:0] ball_b;

    // board right and bottom edges
    logic [coord_w-1:0] board_r;
    logic [coord_w-1:0] board_b;

    // direction, 1 = right / down
    logic dir_x;
    logic dir_y;
    logic dir_x_next;
    logic dir_y_next;

    logic board_hit;

    // one strobe per frame, held off while paused
    assign step = (x == '0) && (y == refresh_row) && !pause;

    assign ball_r  = ball_x + ball_size - 1'b1;
    assign ball_b  = ball_y + ball_size - 1'b1;
    assign board_r = board_x + board_width - 1'b1;
    assign board_b = board_y + board_height - 1'b1;

    // bottom row of the ball inside the board rows, columns overlapping
    assign board_hit = (ball_b >= board_y) && (ball_b <= board_b) &&
                       (ball_r >= board_x) && (ball_x <= board_r);

    // a brick hit only counts on the frame step
    assign collision = step && (|hits);

    // bounce rules, later checks win over earlier ones
    always_comb begin
        dir_x_next = dir_x;
        dir_y_next = dir_y;
        // screen edges
        if (ball_r >= x_max) begin
            dir_x_next = 1'b0;
        end
        if (ball_x == '0) begin
            dir_x_next = 1'b1;
        end
        if (ball_b >= y_max) begin
            dir_y_next = 1'b0;
        end
        if (ball_y == '0) begin
            dir_y_next = 1'b1;
        end
        // board sends the ball back up
        if (board_hit) begin
            dir_y_next = 1'b0;
        end
        // bricks flip the vertical direction held before this step
        if (|hits) begin
            dir_y_next = ~dir_y;
        end
    end

    // ball starts top left, heading right and down
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ball_x <= '0;
            ball_y <= '0;
            dir_x  <= 1'b1;
            dir_y  <= 1'b1;
        end else if (step) begin
            dir_x <= dir_x_next;
            dir_y <= dir_y_next;
            // move uses the old direction, the new one applies next frame
            ball_x <= dir_x ? ball_x + 1'b1 : ball_x - 1'b1;
            ball_y <= dir_y ? ball_y + 1'b1 : ball_y - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/brick_cell.sv
`default_nettype none

module brick_cell (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [breakout_pkg::coord_w-1:0] x,
    input  logic [breakout_pkg::coord_w-1:0] y,
    input  logic [breakout_pkg::coord_w-1:0] ball_x,
    input  logic [breakout_pkg::coord_w-1:0] ball_y,
    input  logic [breakout_pkg::coord_w-1:0] brick_x,
    input  logic [breakout_pkg::coord_w-1:0] brick_y,
    input  logic                             step,
    output logic                             hit,
    output logic                             brick_on
);

    import breakout_pkg::*;

    logic visible;

    // brick right and bottom edges
    logic [coord_w-1:0] brick_r;
    logic [coord_w-1:0] brick_b;

    // ball right and bottom edges
    logic [coord_w-1:0] ball_r;
    logic [coord_w-1:0] ball_b;

    assign brick_r = brick_x + brick_width - 1'b1;
    assign brick_b = brick_y + brick_height - 1'b1;
    assign ball_r  = ball_x + ball_size - 1'b1;
    assign ball_b  = ball_y + ball_size - 1'b1;

    // ball bottom row within the brick rows while the columns overlap
    assign hit = visible &&
                 (ball_b >= brick_y) && (ball_b <= brick_b) &&
                 (ball_r >= brick_x) && (ball_x <= brick_r);

    // raster currently inside this brick
    assign brick_on = visible &&
                      (x >= brick_x) && (x <= brick_r) &&
                      (y >= brick_y) && (y <= brick_b);

    // brick disappears after the frame step that hits it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            visible <= 1'b1;
        end else if (step && hit) begin
            visible <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/score_bcd.sv
`default_nettype none

module score_bcd (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             collision,
    output logic [breakout_pkg::digit_w-1:0] thous,
    output logic [breakout_pkg::digit_w-1:0] huns,
    output logic [breakout_pkg::digit_w-1:0] tens,
    output logic [breakout_pkg::digit_w-1:0] ones
);

    import breakout_pkg::*;

    // digit at 9 passes the carry on
    logic ones_wrap;
    logic tens_wrap;
    logic huns_wrap;
    logic thous_wrap;

    assign ones_wrap  = (ones == 4'd9);
    assign tens_wrap  = ones_wrap && (tens == 4'd9);
    assign huns_wrap  = tens_wrap && (huns == 4'd9);
    assign thous_wrap = huns_wrap && (thous == 4'd9);

    // one count per collision strobe, 9999 wraps to 0000
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ones  <= '0;
            tens  <= '0;
            huns  <= '0;
            thous <= '0;
        end else if (collision) begin
            ones <= ones_wrap ? '0 : ones + 1'b1;
            if (ones_wrap) begin
                tens <= tens_wrap ? '0 : tens + 1'b1;
            end
            if (tens_wrap) begin
                huns <= huns_wrap ? '0 : huns + 1'b1;
            end
            if (huns_wrap) begin
                thous <= thous_wrap ? '0 : thous + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/pixel_render.sv
`default_nettype none

module pixel_render (
    input  logic                                video_on,
    input  logic [breakout_pkg::coord_w-1:0]    x,
    input  logic [breakout_pkg::coord_w-1:0]    y,
    input  logic [breakout_pkg::coord_w-1:0]    board_x,
    input  logic [breakout_pkg::coord_w-1:0]    board_y,
    input  logic [breakout_pkg::coord_w-1:0]    ball_x,
    input  logic [breakout_pkg::coord_w-1:0]    ball_y,
    input  logic [breakout_pkg::num_bricks-1:0] brick_on,
    output logic [breakout_pkg::rgb_w-1:0]      rgb
);

    import breakout_pkg::*;

    logic [coord_w-1:0] board_r;
    logic [coord_w-1:0] board_b;
    logic [coord_w-1:0] ball_r;
    logic [coord_w-1:0] ball_b;

    logic board_on;
    logic ball_on;

    assign board_r = board_x + board_width - 1'b1;
    assign board_b = board_y + board_height - 1'b1;
    assign ball_r  = ball_x + ball_size - 1'b1;
    assign ball_b  = ball_y + ball_size - 1'b1;

    // raster inside the board
    assign board_on = (x >= board_x) && (x <= board_r) &&
                      (y >= board_y) && (y <= board_b);

    // raster inside the ball
    assign ball_on = (x >= ball_x) && (x <= ball_r) &&
                     (y >= ball_y) && (y <= ball_b);

    // board over bricks over ball over background
    always_comb begin
        if (!video_on) begin
            // blank during sync and porches
            rgb = '0;
        end else if (board_on) begin
            rgb = board_rgb;
        end else if (|brick_on) begin
            rgb = brick_rgb;
        end else if (ball_on) begin
            rgb = ball_rgb;
        end else begin
            rgb = bg_rgb;
        end
    end

endmodule

`default_nettype wire

//--- src/breakout_top.sv
`default_nettype none

module breakout_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                pause,
    input  logic                                video_on,
    input  logic [breakout_pkg::coord_w-1:0]    x,
    input  logic [breakout_pkg::coord_w-1:0]    y,
    input  logic [breakout_pkg::coord_w-1:0]    board_x,
    input  logic [breakout_pkg::coord_w-1:0]    board_y,
    input  logic [breakout_pkg::num_bricks-1:0][breakout_pkg::coord_w-1:0] brick_x,
    input  logic [breakout_pkg::num_bricks-1:0][breakout_pkg::coord_w-1:0] brick_y,
    output logic [breakout_pkg::rgb_w-1:0]      rgb,
    output logic                                collision,
    output logic [breakout_pkg::digit_w-1:0]    thous,
    output logic [breakout_pkg::digit_w-1:0]    huns,
    output logic [breakout_pkg::digit_w-1:0]    tens,
    output logic [breakout_pkg::digit_w-1:0]    ones
);

    import breakout_pkg::*;

    // ball top-left corner
    logic [coord_w-1:0] ball_x;
    logic [coord_w-1:0] ball_y;

    // frame step strobe
    logic step;

    // per-brick overlap with the ball and raster coverage
    logic [num_bricks-1:0] hits;
    logic [num_bricks-1:0] brick_on;

    // ball position, direction and bounce logic
    ball_motion u_ball (
        .clk       (clk),
        .reset     (reset),
        .pause     (pause),
        .x         (x),
        .y         (y),
        .board_x   (board_x),
        .board_y   (board_y),
        .hits      (hits),
        .ball_x    (ball_x),
        .ball_y    (ball_y),
        .step      (step),
        .collision (collision)
    );

    // one cell per brick
    for (genvar i = 0; i < num_bricks; i++) begin : g_brick
        brick_cell u_brick (
            .clk      (clk),
            .reset    (reset),
            .x        (x),
            .y        (y),
            .ball_x   (ball_x),
            .ball_y   (ball_y),
            .brick_x  (brick_x[i]),
            .brick_y  (brick_y[i]),
            .step     (step),
            .hit      (hits[i]),
            .brick_on (brick_on[i])
        );
    end

    // hit counter
    score_bcd u_score (
        .clk       (clk),
        .reset     (reset),
        .collision (collision),
        .thous     (thous),
        .huns      (huns),
        .tens      (tens),
        .ones      (ones)
    );

    // colour for the current raster position
    pixel_render u_render (
        .video_on (video_on),
        .x        (x),
        .y        (y),
        .board_x  (board_x),
        .board_y  (board_y),
        .ball_x   (ball_x),
        .ball_y   (ball_y),
        .brick_on (brick_on),
        .rgb      (rgb)
    );

endmodule

`default_nettype wire

//--- dv/breakout_tb.sv
`default_nettype none

module breakout_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import breakout_pkg::*;

    // watchdog budget from steps times (strobe + probe cycles) plus setup at 8 ns, doubled
    localparam int total_steps  = 900;
    localparam int step_cycles  = 2;
    localparam int probe_cycles = 2;
    localparam int setup_cycles = 400;
    localparam int timeout_ns   =
        (total_steps * (step_cycles + probe_cycles) + setup_cycles) * 8 * 2;

    // object sizes as plain integers for the model
    localparam int ball_len   = int'(ball_size);
    localparam int board_w    = int'(board_width);
    localparam int board_h    = int'(board_height);
    localparam int brick_w    = int'(brick_width);
    localparam int brick_h    = int'(brick_height);
    localparam int coord_span = 1 << coord_w;

    logic clk;
    logic reset;
    logic pause;
    logic video_on;
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
    logic [coord_w-1:0] board_x;
    logic [coord_w-1:0] board_y;
    logic [num_bricks-1:0][coord_w-1:0] brick_x;
    logic [num_bricks-1:0][coord_w-1:0] brick_y;
    logic [rgb_w-1:0] rgb;
    logic collision;
    logic [digit_w-1:0] thous;
    logic [digit_w-1:0] huns;
    logic [digit_w-1:0] tens;
    logic [digit_w-1:0] ones;

    // reference model state for ball corner, direction (1 = right / down), bricks and score
    int mx, my;
    logic mdx, mdy;
    logic [num_bricks-1:0] mvis;
    int mscore;
    // layout as driven onto the DUT
    int brd_x, brd_y;
    int bx[num_bricks];
    int by[num_bricks];
    logic paused;
    logic [31:0] seed;
    int errors, test_fails, tests_run, collisions;

    breakout_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog: run still going after %0d ns, stopping", timeout_ns);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // right or bottom edge that wraps like a coord_w-bit sum
    function automatic int far_edge(input int pos, input int size);
        return (pos + size - 1) % coord_span;
    endfunction

    function automatic logic covers(input int px, input int py, input int ox, input int oy,
                                    input int w, input int h);
        return px >= ox && px <= far_edge(ox, w) && py >= oy && py <= far_edge(oy, h);
    endfunction

    // ball bottom row inside the object rows while the columns overlap
    function automatic logic lands_on(input int ox, input int oy, input int w, input int h);
        int bb;
        bb = far_edge(my, ball_len);
        return bb >= oy && bb <= far_edge(oy, h) &&
               far_edge(mx, ball_len) >= ox && mx <= far_edge(ox, w);
    endfunction

    function automatic logic [num_bricks-1:0] brick_hits();
        logic [num_bricks-1:0] h;
        for (int i = 0; i < num_bricks; i++) begin
            h[i] = mvis[i] && lands_on(bx[i], by[i], brick_w, brick_h);
        end
        return h;
    endfunction

    // expected colour with video_on high as board over bricks over ball
    function automatic int model_rgb(input int px, input int py);
        logic brick;
        brick = 1'b0;
        for (int i = 0; i < num_bricks; i++) begin
            brick |= mvis[i] && covers(px, py, bx[i], by[i], brick_w, brick_h);
        end
        return covers(px, py, brd_x, brd_y, board_w, board_h) ? int'(board_rgb) :
               brick ? int'(brick_rgb) :
               covers(px, py, mx, my, ball_len, ball_len) ? int'(ball_rgb) : int'(bg_rgb);
    endfunction

    // one frame step with walls, then board, then bricks, moving with the old direction
    function automatic void model_step();
        logic [num_bricks-1:0] h;
        logic ndx;
        logic ndy;
        h = brick_hits();
        ndx = (mx == 0) ? 1'b1 : (far_edge(mx, ball_len) >= int'(x_max)) ? 1'b0 : mdx;
        ndy = (h != '0) ? ~mdy :
              lands_on(brd_x, brd_y, board_w, board_h) ? 1'b0 :
              (my == 0) ? 1'b1 :
              (far_edge(my, ball_len) >= int'(y_max)) ? 1'b0 : mdy;
        if (h != '0) begin
            mscore = (mscore + 1) % 10000;
        end
        mvis = mvis & ~h;
        mx = (mx + (mdx ? 1 : -1) + coord_span) % coord_span;
        my = (my + (mdy ? 1 : -1) + coord_span) % coord_span;
        mdx = ndx;
        mdy = ndy;
    endfunction

    task automatic report(input string test, input string what, input int exp, input int act);
        $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", test, what, exp, act);
        errors++;
    endtask

    // drive one raster position and compare the colour while collision stays low
    task automatic probe(input string test, input int px, input int py, input logic von,
                         input int exp);
        @(posedge clk);
        x <= coord_w'(px);
        y <= coord_w'(py);
        video_on <= von;
        @(negedge clk);
        if (rgb !== rgb_w'(exp)) begin
            report(test, $sformatf("rgb at %0d,%0d", px, py), exp, int'(rgb));
        end
        if (collision !== 1'b0) begin
            report(test, "collision outside a step", 0, int'(collision));
        end
    endtask

    // one cycle at the refresh row and then the raster parks off screen
    task automatic frame_step(input string test);
        logic exp_col;
        exp_col = !paused && (brick_hits() != '0);
        @(posedge clk);
        x <= '0;
        y <= refresh_row;
        pause <= paused;
        @(negedge clk);
        if (collision !== exp_col) begin
            report(test, "collision", int'(exp_col), int'(collision));
        end
        if (collision === 1'b1) begin
            collisions++;
        end
        @(posedge clk);
        x <= coord_w'(700);
        y <= coord_w'(500);
        if (!paused) begin
            model_step();
        end
    endtask

    // steps with the ball's two opposite corners probed after each
    task automatic track_ball(input string test, input int steps);
        for (int n = 0; n < steps; n++) begin
            frame_step(test);
            probe(test, mx, my, 1'b1, model_rgb(mx, my));
            probe(test, mx + 7, my + 7, 1'b1, model_rgb(mx + 7, my + 7));
        end
    endtask

    task automatic drive_layout();
        logic [num_bricks-1:0][coord_w-1:0] nx;
        logic [num_bricks-1:0][coord_w-1:0] ny;
        for (int i = 0; i < num_bricks; i++) begin
            nx[i] = coord_w'(bx[i]);
            ny[i] = coord_w'(by[i]);
        end
        @(posedge clk);
        board_x <= coord_w'(brd_x);
        board_y <= coord_w'(brd_y);
        brick_x <= nx;
        brick_y <= ny;
    endtask

    // board where asked with bricks parked right of the visible area
    task automatic place(input int bdx, input int bdy);
        brd_x = bdx;
        brd_y = bdy;
        for (int i = 0; i < num_bricks; i++) begin
            bx[i] = 700 + 50 * i;
            by[i] = 400;
        end
        drive_layout();
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        mx = 0;
        my = 0;
        mdx = 1'b1;
        mdy = 1'b1;
        mvis = '1;
        mscore = 0;
        collisions = 0;
    endtask

    task automatic end_test(input string test, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("%s: pass", test);
        end else begin
            test_fails++;
            $display("%s: FAIL with %0d errors", test, errors - errs_before);
        end
    endtask

    task automatic render_test();
        int e0;
        int px;
        int py;
        int found;
        e0 = errors;
        apply_reset();
        place(100, 100);
        // brick 0 under the board's left end and the others in a row lower down
        bx[0] = 120;
        by[0] = 90;
        for (int i = 1; i < num_bricks; i++) begin
            bx[i] = 200 + 40 * i;
            by[i] = 200;
        end
        drive_layout();
        probe("render", 125, 102, 1'b1, int'(board_rgb));
        probe("render", 125, 95, 1'b1, int'(brick_rgb));
        probe("render", 325, 210, 1'b1, int'(brick_rgb));
        for (int i = 0; i < 64; i++) begin
            probe("render", i % 8, i / 8, 1'b1, int'(ball_rgb));
        end
        found = 0;
        while (found < 16) begin
            seed = lcg(seed);
            px = int'(seed[31:22]) % 640;
            seed = lcg(seed);
            py = int'(seed[31:22]) % 480;
            if (model_rgb(px, py) == int'(bg_rgb)) begin
                probe("render", px, py, 1'b1, int'(bg_rgb));
                found++;
            end
        end
        // blanking reads zero over board, brick, ball and background
        probe("render", 125, 102, 1'b0, 0);
        probe("render", 125, 95, 1'b0, 0);
        probe("render", 3, 3, 1'b0, 0);
        probe("render", px, py, 1'b0, 0);
        end_test("render", e0);
    endtask

    task automatic motion_test();
        int e0;
        e0 = errors;
        apply_reset();
        place(900, 0);
        repeat (5) frame_step("motion");
        probe("motion", 5, 5, 1'b1, int'(ball_rgb));
        probe("motion", 13, 5, 1'b1, int'(bg_rgb));
        probe("motion", 4, 5, 1'b1, int'(bg_rgb));
        // paused strobes over a brick sitting on the ball
        bx[0] = 5;
        by[0] = 5;
        drive_layout();
        paused = 1'b1;
        repeat (3) frame_step("motion");
        probe("motion", 20, 20, 1'b1, int'(brick_rgb));
        paused = 1'b0;
        place(900, 0);
        probe("motion", 5, 5, 1'b1, int'(ball_rgb));
        probe("motion", 4, 4, 1'b1, int'(bg_rgb));
        frame_step("motion");
        probe("motion", 6, 6, 1'b1, int'(ball_rgb));
        probe("motion", 5, 6, 1'b1, int'(bg_rgb));
        end_test("motion", e0);
    endtask

    task automatic wall_test();
        int e0;
        e0 = errors;
        apply_reset();
        place(900, 0);
        track_ball("wall", 700);
        // bottom reached at y 473, right edge at x 633, corner now at 566,246
        probe("wall", 566, 246, 1'b1, int'(ball_rgb));
        probe("wall", 565, 246, 1'b1, int'(bg_rgb));
        probe("wall", 566, 245, 1'b1, int'(bg_rgb));
        end_test("wall", e0);
    endtask

    task automatic board_test();
        int e0;
        e0 = errors;
        apply_reset();
        place(40, 60);
        track_ball("board", 60);
        // turned up on the step from 53,53
        probe("board", 60, 48, 1'b1, int'(ball_rgb));
        probe("board", 60, 47, 1'b1, int'(bg_rgb));
        end_test("board", e0);
    endtask

    task automatic brick_test();
        int e0;
        e0 = errors;
        apply_reset();
        place(900, 0);
        bx[0] = 30;
        by[0] = 50;
        drive_layout();
        for (int n = 0; n < 100 && mscore == 0; n++) begin
            frame_step("brick");
        end
        // score settles on the edge that ends the step
        @(negedge clk);
        if (collisions != 1) begin
            report("brick", "collision strobes", 1, collisions);
        end
        if ({thous, huns, tens, ones} !== 16'h0001) begin
            report("brick", "score", 'h0001, int'({thous, huns, tens, ones}));
        end
        probe("brick", 35, 75, 1'b1, int'(bg_rgb));
        // ball still overlaps the cleared brick here
        frame_step("brick");
        // three more bricks dropped onto the ball with one per strobe
        for (int i = 1; i < 4; i++) begin
            bx[i] = mx;
            by[i] = my;
            drive_layout();
            frame_step("brick");
        end
        @(negedge clk);
        if (collisions != 4) begin
            report("brick", "collision strobes", 4, collisions);
        end
        if ({thous, huns, tens, ones} !== 16'h0004) begin
            report("brick", "score", 'h0004, int'({thous, huns, tens, ones}));
        end
        end_test("brick", e0);
    endtask

    initial begin
        reset <= 1'b1;
        pause <= 1'b0;
        video_on <= 1'b0;
        x <= coord_w'(700);
        y <= coord_w'(500);
        board_x <= '0;
        board_y <= '0;
        brick_x <= '0;
        brick_y <= '0;
        paused = 1'b0;
        seed = 32'hb53f6d86;
        errors = 0;
        test_fails = 0;
        tests_run = 0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        render_test();
        motion_test();
        wall_test();
        board_test();
        brick_test();
        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, test_fails, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- breakout_top.f
src/breakout_pkg.sv
src/ball_motion.sv
src/brick_cell.sv
src/score_bcd.sv
src/pixel_render.sv
src/breakout_top.sv
dv/breakout_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the breakout testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f breakout_top.f --top-module breakout_tb -o breakout_sim \
    && ./obj_dir/breakout_sim | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }
grep -q "All tests passed!" sim.log && exit 0 || exit 1
